// ==== hdl/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    localparam int wordWidth = 16;
    localparam int regCount = 4;
    localparam int regIdxWidth = $clog2(regCount);
    localparam logic [regIdxWidth-1:0] linkReg = regIdxWidth'(2);

    // opcodes in instr[15:12]
    localparam logic [3:0] opBne = 4'd0;
    localparam logic [3:0] opBeq = 4'd1;
    localparam logic [3:0] opBgz = 4'd2;
    localparam logic [3:0] opBlz = 4'd3;
    localparam logic [3:0] opAdi = 4'd4;
    localparam logic [3:0] opOri = 4'd5;
    localparam logic [3:0] opLhi = 4'd6;
    localparam logic [3:0] opLwd = 4'd7;
    localparam logic [3:0] opSwd = 4'd8;
    localparam logic [3:0] opJmp = 4'd9;
    localparam logic [3:0] opJal = 4'd10;
    localparam logic [3:0] opRType = 4'd15;

    // func codes in instr[5:0] under opRType
    localparam logic [5:0] fnAdd = 6'd0;
    localparam logic [5:0] fnSub = 6'd1;
    localparam logic [5:0] fnAnd = 6'd2;
    localparam logic [5:0] fnOrr = 6'd3;
    localparam logic [5:0] fnNot = 6'd4;
    localparam logic [5:0] fnTcp = 6'd5;
    localparam logic [5:0] fnShl = 6'd6;
    localparam logic [5:0] fnShr = 6'd7;
    localparam logic [5:0] fnJpr = 6'd25;
    localparam logic [5:0] fnJrl = 6'd26;
    localparam logic [5:0] fnWwd = 6'd28;
    localparam logic [5:0] fnHlt = 6'd29;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluNot,
        aluTcp,
        aluShl,
        aluShr,
        aluLhi,
        aluPassA
    } aluOpT;

    typedef struct packed {
        logic regWrite;
        logic memToReg;
        logic memRead;
        logic memWrite;
        logic wwd;
        logic isBranch;
        logic isJumpReg;
        logic linkPc;
        logic aluSrcImm;
        aluOpT aluOp;
        logic isHalt;
    } ctrlT;

    typedef struct packed {
        logic [wordWidth-1:0] instr;
        logic [wordWidth-1:0] pc;
    } fetchedT;

    // pc is the address of the next instruction
    typedef struct packed {
        logic [wordWidth-1:0] pc;
        logic [regIdxWidth-1:0] rs;
        logic [regIdxWidth-1:0] rt;
        logic [regIdxWidth-1:0] rd;
        logic [wordWidth-1:0] rsValue;
        logic [wordWidth-1:0] rtValue;
        logic [wordWidth-1:0] imm;
        logic [3:0] opcode;
        ctrlT ctrl;
    } decodedT;

    typedef struct packed {
        logic [wordWidth-1:0] aluResult;
        logic [wordWidth-1:0] storeData;
        logic [regIdxWidth-1:0] rd;
        ctrlT ctrl;
    } executedT;

    typedef struct packed {
        logic [wordWidth-1:0] aluResult;
        logic [wordWidth-1:0] loadData;
        logic [regIdxWidth-1:0] rd;
        ctrlT ctrl;
    } retiringT;

endpackage

`default_nettype wire

// ==== hdl/stageLink.sv ====
`timescale 1ns/1ns
`default_nettype none

// one pipeline register between two adjacent stages
interface stageLink #(
    parameter type payloadT = logic
) ();
    logic valid;
    payloadT payload;
    logic hold;
    logic kill;

    // the upstream stage owns the register
    modport source (
        output valid,
        output payload,
        input hold,
        input kill
    );

    modport sink (
        input valid,
        input payload,
        output hold,
        output kill
    );

    // forwarding tap, reads contents only
    modport monitor (
        input valid,
        input payload
    );
endinterface

`default_nettype wire

// ==== hdl/fetchStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetchStage (
    input wire Clk,
    input wire rstN,
    input wire halted,
    output logic [cpuPkg::wordWidth-1:0] instrAddress,
    input wire [cpuPkg::wordWidth-1:0] instrData,
    input wire redirect,
    input wire [cpuPkg::wordWidth-1:0] redirectPc,
    input wire jumpTaken,
    input wire [cpuPkg::wordWidth-1:0] jumpPc,
    stageLink.source toDecode
);
    import cpuPkg::*;

    logic [wordWidth-1:0] pc;
    logic [wordWidth-1:0] pcPlusOne;
    logic [wordWidth-1:0] nextPc;

    assign instrAddress = pc;
    assign pcPlusOne = pc + 1'b1;

    // hold wins, then the older redirect from execute
    always_comb begin
        if (toDecode.hold || halted) begin
            nextPc = pc;
        end else if (redirect) begin
            nextPc = redirectPc;
        end else if (jumpTaken) begin
            nextPc = jumpPc;
        end else begin
            nextPc = pcPlusOne;
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            toDecode.valid <= 1'b0;
        end else if (!toDecode.hold) begin
            toDecode.valid <= !(redirect || toDecode.kill || halted);
        end
    end

    always_ff @(posedge Clk) begin
        if (!toDecode.hold) begin
            toDecode.payload.instr <= instrData;
            toDecode.payload.pc <= pcPlusOne;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/decodeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
    input wire Clk,
    input wire rstN,
    stageLink.sink fromFetch,
    stageLink.source toExecute,
    output logic jumpTaken,
    output logic [cpuPkg::wordWidth-1:0] jumpPc,
    input wire wbWrite,
    input wire [cpuPkg::regIdxWidth-1:0] wbRd,
    input wire [cpuPkg::wordWidth-1:0] wbData
);
    import cpuPkg::*;

    logic [wordWidth-1:0] instr;
    logic [3:0] opcode;
    logic [5:0] func;
    logic [regIdxWidth-1:0] rs;
    logic [regIdxWidth-1:0] rt;
    logic [regIdxWidth-1:0] rd;
    logic usesRs;
    logic usesRt;
    logic loadUse;
    ctrlT ctrl;
    logic [wordWidth-1:0] regs [regCount];
    logic [wordWidth-1:0] rsValue;
    logic [wordWidth-1:0] rtValue;

    assign instr = fromFetch.payload.instr;
    assign opcode = instr[15:12];
    assign rs = instr[11:10];
    assign rt = instr[9:8];
    assign func = instr[5:0];

    always_comb begin
        ctrl = '0;
        case (opcode)
            opAdi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = aluAdd;
            end
            opOri: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = aluOr;
            end
            opLhi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp = aluLhi;
            end
            opLwd: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opSwd: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opBne, opBeq, opBgz, opBlz: ctrl.isBranch = 1'b1;
            opJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.linkPc = 1'b1;
            end
            opRType: begin
                case (func)
                    fnAdd: ctrl.aluOp = aluAdd;
                    fnSub: ctrl.aluOp = aluSub;
                    fnAnd: ctrl.aluOp = aluAnd;
                    fnOrr: ctrl.aluOp = aluOr;
                    fnNot: ctrl.aluOp = aluNot;
                    fnTcp: ctrl.aluOp = aluTcp;
                    fnShl: ctrl.aluOp = aluShl;
                    fnShr: ctrl.aluOp = aluShr;
                    fnWwd: begin
                        ctrl.wwd = 1'b1;
                        ctrl.aluOp = aluPassA;
                    end
                    fnJpr: ctrl.isJumpReg = 1'b1;
                    fnJrl: begin
                        ctrl.isJumpReg = 1'b1;
                        ctrl.linkPc = 1'b1;
                    end
                    fnHlt: ctrl.isHalt = 1'b1;
                    default: ctrl.aluOp = aluAdd;
                endcase
                // arithmetic and logic funcs write rd
                ctrl.regWrite = ctrl.linkPc || (func <= fnShr);
            end
            default: ctrl.aluOp = aluAdd;
        endcase
    end

    always_comb begin
        if (ctrl.linkPc) begin
            rd = linkReg;
        end else if (opcode == opRType) begin
            rd = instr[7:6];
        end else begin
            rd = rt;
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrite) begin
            regs[wbRd] <= wbData;
        end
    end

    // same-cycle writeback is visible to the read
    assign rsValue = (wbWrite && wbRd == rs) ? wbData : regs[rs];
    assign rtValue = (wbWrite && wbRd == rt) ? wbData : regs[rt];

    assign usesRs = !(opcode == opJmp || opcode == opJal || opcode == opLhi);
    assign usesRt = opcode == opBne || opcode == opBeq || opcode == opSwd
        || (opcode == opRType && func <= fnOrr);

    // a load one slot ahead has no data to forward yet
    assign loadUse = fromFetch.valid && toExecute.valid && toExecute.payload.ctrl.memRead
        && ((usesRs && toExecute.payload.rd == rs) || (usesRt && toExecute.payload.rd == rt));

    assign jumpTaken = fromFetch.valid && !toExecute.hold
        && (opcode == opJmp || opcode == opJal);
    assign jumpPc = {fromFetch.payload.pc[wordWidth-1:wordWidth-4], instr[11:0]};

    assign fromFetch.hold = loadUse || toExecute.hold;
    assign fromFetch.kill = jumpTaken;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            toExecute.valid <= 1'b0;
        end else if (!toExecute.hold) begin
            toExecute.valid <= fromFetch.valid && !loadUse && !toExecute.kill;
        end
    end

    always_ff @(posedge Clk) begin
        if (!toExecute.hold) begin
            toExecute.payload.pc <= fromFetch.payload.pc;
            toExecute.payload.rs <= rs;
            toExecute.payload.rt <= rt;
            toExecute.payload.rd <= rd;
            toExecute.payload.rsValue <= rsValue;
            toExecute.payload.rtValue <= rtValue;
            toExecute.payload.imm <= {{(wordWidth - 8){instr[7]}}, instr[7:0]};
            toExecute.payload.opcode <= opcode;
            toExecute.payload.ctrl <= ctrl;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/executeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module executeStage (
    input wire Clk,
    input wire rstN,
    stageLink.sink fromDecode,
    stageLink.source toMemory,
    stageLink.monitor fromWriteback,
    input wire [cpuPkg::wordWidth-1:0] wbData,
    output logic redirect,
    output logic [cpuPkg::wordWidth-1:0] redirectPc
);
    import cpuPkg::*;

    decodedT cur;
    logic memFwdOk;
    logic wbFwdOk;
    logic [wordWidth-1:0] fwdRs;
    logic [wordWidth-1:0] fwdRt;
    logic [wordWidth-1:0] opB;
    logic [wordWidth-1:0] aluOut;
    logic [wordWidth-1:0] result;
    logic branchCond;

    assign cur = fromDecode.payload;

    // a load in the memory stage is never a source here
    assign memFwdOk = toMemory.valid && toMemory.payload.ctrl.regWrite
        && !toMemory.payload.ctrl.memToReg;
    assign wbFwdOk = fromWriteback.valid && fromWriteback.payload.ctrl.regWrite;

    // the younger producer in memory takes precedence
    always_comb begin
        if (memFwdOk && toMemory.payload.rd == cur.rs) begin
            fwdRs = toMemory.payload.aluResult;
        end else if (wbFwdOk && fromWriteback.payload.rd == cur.rs) begin
            fwdRs = wbData;
        end else begin
            fwdRs = cur.rsValue;
        end
        if (memFwdOk && toMemory.payload.rd == cur.rt) begin
            fwdRt = toMemory.payload.aluResult;
        end else if (wbFwdOk && fromWriteback.payload.rd == cur.rt) begin
            fwdRt = wbData;
        end else begin
            fwdRt = cur.rtValue;
        end
    end

    assign opB = cur.ctrl.aluSrcImm ? cur.imm : fwdRt;

    always_comb begin
        case (cur.ctrl.aluOp)
            aluAdd: aluOut = fwdRs + opB;
            aluSub: aluOut = fwdRs - opB;
            aluAnd: aluOut = fwdRs & opB;
            aluOr: aluOut = fwdRs | opB;
            aluNot: aluOut = ~fwdRs;
            aluTcp: aluOut = ~fwdRs + 1'b1;
            aluShl: aluOut = fwdRs << 1;
            aluShr: aluOut = $signed(fwdRs) >>> 1;
            aluLhi: aluOut = {cur.imm[7:0], 8'h00};
            default: aluOut = fwdRs;
        endcase
    end

    assign result = cur.ctrl.linkPc ? cur.pc : aluOut;

    always_comb begin
        case (cur.opcode)
            opBne: branchCond = fwdRs != fwdRt;
            opBeq: branchCond = fwdRs == fwdRt;
            opBgz: branchCond = $signed(fwdRs) > 0;
            opBlz: branchCond = $signed(fwdRs) < 0;
            default: branchCond = 1'b0;
        endcase
    end

    assign redirect = fromDecode.valid && !toMemory.hold
        && ((cur.ctrl.isBranch && branchCond) || cur.ctrl.isJumpReg);
    assign redirectPc = cur.ctrl.isJumpReg ? fwdRs : cur.pc + cur.imm;

    // drop the instruction in decode, fetch bubbles on redirect itself
    assign fromDecode.kill = redirect;
    assign fromDecode.hold = toMemory.hold;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            toMemory.valid <= 1'b0;
        end else if (!toMemory.hold) begin
            toMemory.valid <= fromDecode.valid && !toMemory.kill;
        end
    end

    always_ff @(posedge Clk) begin
        if (!toMemory.hold) begin
            toMemory.payload.aluResult <= result;
            toMemory.payload.storeData <= fwdRt;
            toMemory.payload.rd <= cur.rd;
            toMemory.payload.ctrl <= cur.ctrl;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/memoryStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module memoryStage (
    input wire Clk,
    input wire rstN,
    stageLink.sink fromExecute,
    stageLink.source toWriteback,
    output logic [cpuPkg::wordWidth-1:0] dataAddress,
    output logic dataWrite,
    output logic [cpuPkg::wordWidth-1:0] dataWriteData,
    input wire [cpuPkg::wordWidth-1:0] dataReadData
);
    logic haltSeen;

    assign dataAddress = fromExecute.payload.aluResult;
    assign dataWriteData = fromExecute.payload.storeData;
    assign dataWrite = fromExecute.valid && fromExecute.payload.ctrl.memWrite
        && !toWriteback.hold;

    // nothing younger than a committed halt reaches memory
    assign fromExecute.kill = haltSeen
        || (fromExecute.valid && fromExecute.payload.ctrl.isHalt);
    assign fromExecute.hold = toWriteback.hold;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            haltSeen <= 1'b0;
        end else if (fromExecute.valid && fromExecute.payload.ctrl.isHalt
                && !toWriteback.hold) begin
            haltSeen <= 1'b1;
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            toWriteback.valid <= 1'b0;
        end else if (!toWriteback.hold) begin
            toWriteback.valid <= fromExecute.valid && !toWriteback.kill;
        end
    end

    always_ff @(posedge Clk) begin
        if (!toWriteback.hold) begin
            toWriteback.payload.aluResult <= fromExecute.payload.aluResult;
            toWriteback.payload.loadData <= dataReadData;
            toWriteback.payload.rd <= fromExecute.payload.rd;
            toWriteback.payload.ctrl <= fromExecute.payload.ctrl;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/writebackStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module writebackStage (
    input wire Clk,
    input wire rstN,
    stageLink.sink fromMemory,
    output logic wbWrite,
    output logic [cpuPkg::regIdxWidth-1:0] wbRd,
    output logic [cpuPkg::wordWidth-1:0] wbData,
    output logic [cpuPkg::wordWidth-1:0] outputPort,
    output logic wwdValid,
    output logic [cpuPkg::wordWidth-1:0] retiredCount,
    output logic halted
);
    logic retire;

    assign retire = fromMemory.valid && !halted;

    assign wbData = fromMemory.payload.ctrl.memToReg ? fromMemory.payload.loadData
        : fromMemory.payload.aluResult;
    assign wbWrite = retire && fromMemory.payload.ctrl.regWrite;
    assign wbRd = fromMemory.payload.rd;

    assign fromMemory.hold = 1'b0;
    assign fromMemory.kill = halted;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            retiredCount <= '0;
            outputPort <= '0;
            wwdValid <= 1'b0;
            halted <= 1'b0;
        end else begin
            wwdValid <= retire && fromMemory.payload.ctrl.wwd;
            if (retire) begin
                retiredCount <= retiredCount + 1'b1;
                if (fromMemory.payload.ctrl.wwd) begin
                    outputPort <= fromMemory.payload.aluResult;
                end
                if (fromMemory.payload.ctrl.isHalt) begin
                    halted <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cpuCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuCore (
    input wire Clk,
    input wire rstN,
    output logic [cpuPkg::wordWidth-1:0] instrAddress,
    input wire [cpuPkg::wordWidth-1:0] instrData,
    output logic [cpuPkg::wordWidth-1:0] dataAddress,
    output logic dataWrite,
    output logic [cpuPkg::wordWidth-1:0] dataWriteData,
    input wire [cpuPkg::wordWidth-1:0] dataReadData,
    output logic [cpuPkg::wordWidth-1:0] outputPort,
    output logic wwdValid,
    output logic [cpuPkg::wordWidth-1:0] retiredCount,
    output logic halted
);
    import cpuPkg::*;

    logic redirect;
    logic [wordWidth-1:0] redirectPc;
    logic jumpTaken;
    logic [wordWidth-1:0] jumpPc;
    logic wbWrite;
    logic [regIdxWidth-1:0] wbRd;
    logic [wordWidth-1:0] wbData;

    stageLink #(.payloadT(fetchedT)) fetchToDecode ();
    stageLink #(.payloadT(decodedT)) decodeToExecute ();
    stageLink #(.payloadT(executedT)) executeToMemory ();
    stageLink #(.payloadT(retiringT)) memoryToWriteback ();

    fetchStage fetchStage_inst (
        .Clk(Clk),
        .rstN(rstN),
        .halted(halted),
        .instrAddress(instrAddress),
        .instrData(instrData),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .jumpTaken(jumpTaken),
        .jumpPc(jumpPc),
        .toDecode(fetchToDecode.source)
    );

    decodeStage decodeStage_inst (
        .Clk(Clk),
        .rstN(rstN),
        .fromFetch(fetchToDecode.sink),
        .toExecute(decodeToExecute.source),
        .jumpTaken(jumpTaken),
        .jumpPc(jumpPc),
        .wbWrite(wbWrite),
        .wbRd(wbRd),
        .wbData(wbData)
    );

    executeStage executeStage_inst (
        .Clk(Clk),
        .rstN(rstN),
        .fromDecode(decodeToExecute.sink),
        .toMemory(executeToMemory.source),
        .fromWriteback(memoryToWriteback.monitor),
        .wbData(wbData),
        .redirect(redirect),
        .redirectPc(redirectPc)
    );

    memoryStage memoryStage_inst (
        .Clk(Clk),
        .rstN(rstN),
        .fromExecute(executeToMemory.sink),
        .toWriteback(memoryToWriteback.source),
        .dataAddress(dataAddress),
        .dataWrite(dataWrite),
        .dataWriteData(dataWriteData),
        .dataReadData(dataReadData)
    );

    writebackStage writebackStage_inst (
        .Clk(Clk),
        .rstN(rstN),
        .fromMemory(memoryToWriteback.sink),
        .wbWrite(wbWrite),
        .wbRd(wbRd),
        .wbData(wbData),
        .outputPort(outputPort),
        .wwdValid(wwdValid),
        .retiredCount(retiredCount),
        .halted(halted)
    );

endmodule

`default_nettype wire

// ==== tb/cpuCoreTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuCoreTb;
    import cpuPkg::*;

    logic Clk;
    logic rstN;
    logic [wordWidth-1:0] instrAddress;
    logic [wordWidth-1:0] instrData;
    logic [wordWidth-1:0] dataAddress;
    logic dataWrite;
    logic [wordWidth-1:0] dataWriteData;
    logic [wordWidth-1:0] dataReadData;
    logic [wordWidth-1:0] outputPort;
    logic wwdValid;
    logic [wordWidth-1:0] retiredCount;
    logic halted;

    // one row per program: name, cycle budget and up to 32 words
    string progName [4];
    int progCycles [4];
    logic [15:0] progTable [4][32];
    int buildRow;
    int buildLen;
    int curProg;

    logic [15:0] imem [32];
    logic [15:0] dmem [256];
    logic [15:0] modelMem [256];
    logic [15:0] expWwd [$];
    int expRetired;
    logic [31:0] lfsrState;
    int mismatches;
    int failures;

    cpuCore cpuCore_inst (
        .Clk(Clk),
        .rstN(rstN),
        .instrAddress(instrAddress),
        .instrData(instrData),
        .dataAddress(dataAddress),
        .dataWrite(dataWrite),
        .dataWriteData(dataWriteData),
        .dataReadData(dataReadData),
        .outputPort(outputPort),
        .wwdValid(wwdValid),
        .retiredCount(retiredCount),
        .halted(halted)
    );

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    // zero-wait memories, read is combinational
    assign instrData = (instrAddress < 16'd32) ? imem[instrAddress[4:0]] : 16'h0000;
    assign dataReadData = dmem[dataAddress[7:0]];

    function automatic logic [15:0] fillWord(input int a);
        return 16'(a * 40503) ^ 16'h5ac3;
    endfunction

    // memories are loaded while reset is held
    always @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                imem[i] <= progTable[curProg][i];
            end
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= fillWord(i);
            end
        end else if (dataWrite) begin
            dmem[dataAddress[7:0]] <= dataWriteData;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] randomByte();
        logic [7:0] b;
        b = 8'h00;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsrBit()};
        end
        return b;
    endfunction

    function automatic logic [15:0] encR(input logic [5:0] fn, input logic [1:0] rs,
            input logic [1:0] rt, input logic [1:0] rd);
        return {opRType, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] encI(input logic [3:0] op, input logic [1:0] rs,
            input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] encJ(input logic [3:0] op, input logic [11:0] target);
        return {op, target};
    endfunction

    task automatic startRow(input int row, input string name, input int maxCycles);
        buildRow = row;
        buildLen = 0;
        progName[row] = name;
        progCycles[row] = maxCycles;
        for (int i = 0; i < 32; i++) begin
            progTable[row][i] = 16'h0000;
        end
    endtask

    task automatic put(input logic [15:0] word);
        progTable[buildRow][buildLen] = word;
        buildLen++;
    endtask

    task automatic buildPrograms();
        // back to back ALU ops, forwarding from memory and writeback
        startRow(0, "alu", 200);
        put(encI(opLhi, 2'd0, 2'd1, 8'h12));
        put(encI(opOri, 2'd1, 2'd1, 8'h34));
        put(encI(opAdi, 2'd0, 2'd2, 8'h05));
        put(encR(fnAdd, 2'd1, 2'd2, 2'd3));
        put(encR(fnWwd, 2'd3, 2'd0, 2'd0));
        put(encR(fnSub, 2'd3, 2'd1, 2'd0));
        put(encR(fnTcp, 2'd0, 2'd0, 2'd0));
        put(encR(fnWwd, 2'd0, 2'd0, 2'd0));
        put(encR(fnAnd, 2'd1, 2'd0, 2'd3));
        put(encR(fnOrr, 2'd3, 2'd2, 2'd2));
        put(encR(fnNot, 2'd2, 2'd0, 2'd1));
        put(encR(fnShl, 2'd1, 2'd0, 2'd2));
        put(encR(fnShr, 2'd0, 2'd0, 2'd3));
        put(encR(fnWwd, 2'd1, 2'd0, 2'd0));
        put(encR(fnWwd, 2'd2, 2'd0, 2'd0));
        put(encR(fnWwd, 2'd3, 2'd0, 2'd0));
        put(encI(opAdi, 2'd1, 2'd1, 8'h80));
        put(encR(fnWwd, 2'd1, 2'd0, 2'd0));
        put(encR(fnHlt, 2'd0, 2'd0, 2'd0));

        // load-use stalls and store then load
        startRow(1, "memory", 200);
        put(encI(opAdi, 2'd0, 2'd1, 8'h10));
        put(encI(opAdi, 2'd0, 2'd2, 8'h3c));
        put(encI(opSwd, 2'd1, 2'd2, 8'h00));
        put(encI(opLwd, 2'd1, 2'd3, 8'h00));
        put(encR(fnAdd, 2'd3, 2'd3, 2'd0));
        put(encR(fnWwd, 2'd0, 2'd0, 2'd0));
        put(encI(opLwd, 2'd1, 2'd2, 8'h04));
        put(encR(fnWwd, 2'd2, 2'd0, 2'd0));
        put(encI(opLwd, 2'd1, 2'd3, 8'hff));
        put(encI(opSwd, 2'd1, 2'd3, 8'h05));
        put(encI(opLwd, 2'd1, 2'd0, 8'h05));
        put(encR(fnSub, 2'd0, 2'd3, 2'd1));
        put(encR(fnWwd, 2'd1, 2'd0, 2'd0));
        put(encI(opSwd, 2'd0, 2'd0, 8'h01));
        put(encR(fnHlt, 2'd0, 2'd0, 2'd0));

        // every WWD in a flushed slot would show up in the sequence
        startRow(2, "control", 300);
        put(encI(opAdi, 2'd0, 2'd1, 8'h01));
        put(encI(opAdi, 2'd0, 2'd3, 8'hff));
        put(encI(opBne, 2'd1, 2'd0, 8'd2));
        put(encR(fnWwd, 2'd1, 2'd0, 2'd0));
        put(encR(fnWwd, 2'd3, 2'd0, 2'd0));
        put(encI(opBeq, 2'd1, 2'd0, 8'd1));
        put(encR(fnWwd, 2'd1, 2'd0, 2'd0));
        put(encI(opBeq, 2'd1, 2'd1, 8'd1));
        put(encR(fnWwd, 2'd3, 2'd0, 2'd0));
        put(encI(opBgz, 2'd1, 2'd0, 8'd1));
        put(encR(fnWwd, 2'd3, 2'd0, 2'd0));
        put(encI(opBgz, 2'd3, 2'd0, 8'd1));
        put(encI(opBlz, 2'd1, 2'd0, 8'd1));
        put(encI(opBlz, 2'd3, 2'd0, 8'd1));
        put(encR(fnWwd, 2'd1, 2'd0, 2'd0));
        put(encI(opBne, 2'd1, 2'd1, 8'd1));
        put(encJ(opJmp, 12'd18));
        put(encR(fnWwd, 2'd3, 2'd0, 2'd0));
        put(encJ(opJal, 12'd22));
        put(encR(fnWwd, 2'd3, 2'd0, 2'd0));
        put(encR(fnJrl, 2'd0, 2'd0, 2'd0));
        put(encR(fnWwd, 2'd1, 2'd0, 2'd0));
        put(encR(fnWwd, 2'd2, 2'd0, 2'd0));
        put(encI(opAdi, 2'd0, 2'd0, 8'd26));
        put(encR(fnJpr, 2'd2, 2'd0, 2'd0));
        put(encR(fnWwd, 2'd1, 2'd0, 2'd0));
        put(encR(fnWwd, 2'd2, 2'd0, 2'd0));
        put(encR(fnHlt, 2'd0, 2'd0, 2'd0));

        // random constants in all registers, then a dependent ALU chain
        startRow(3, "random alu", 200);
        for (int r = 0; r < 4; r++) begin
            put(encI(opLhi, 2'd0, 2'(r), randomByte()));
            put(encI(opOri, 2'(r), 2'(r), randomByte()));
        end
        put(encR(fnAdd, 2'd1, 2'd2, 2'd0));
        put(encR(fnWwd, 2'd0, 2'd0, 2'd0));
        put(encR(fnSub, 2'd0, 2'd3, 2'd1));
        put(encR(fnWwd, 2'd1, 2'd0, 2'd0));
        put(encR(fnAnd, 2'd1, 2'd0, 2'd2));
        put(encR(fnWwd, 2'd2, 2'd0, 2'd0));
        put(encR(fnOrr, 2'd2, 2'd1, 2'd3));
        put(encR(fnWwd, 2'd3, 2'd0, 2'd0));
        put(encR(fnTcp, 2'd3, 2'd0, 2'd0));
        put(encR(fnShr, 2'd0, 2'd0, 2'd1));
        put(encR(fnWwd, 2'd1, 2'd0, 2'd0));
        put(encR(fnNot, 2'd1, 2'd0, 2'd2));
        put(encR(fnShl, 2'd2, 2'd0, 2'd3));
        put(encR(fnWwd, 2'd3, 2'd0, 2'd0));
        put(encI(opAdi, 2'd3, 2'd0, randomByte()));
        put(encR(fnWwd, 2'd0, 2'd0, 2'd0));
        put(encR(fnHlt, 2'd0, 2'd0, 2'd0));
    endtask

    // one instruction per step, no pipeline
    task automatic runModel(input int p);
        logic [15:0] r [4];
        logic [15:0] pc;
        logic [15:0] ins;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] imm;
        logic [15:0] addr;
        logic [15:0] next;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        logic done;
        int steps;
        for (int i = 0; i < 4; i++) begin
            r[i] = 16'h0000;
        end
        for (int i = 0; i < 256; i++) begin
            modelMem[i] = fillWord(i);
        end
        expWwd.delete();
        expRetired = 0;
        pc = 16'h0000;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 500) begin
            ins = (pc < 16'd32) ? progTable[p][pc[4:0]] : 16'h0000;
            rs = ins[11:10];
            rt = ins[9:8];
            rd = ins[7:6];
            a = r[rs];
            b = r[rt];
            imm = {{8{ins[7]}}, ins[7:0]};
            addr = a + imm;
            next = pc + 16'd1;
            expRetired++;
            steps++;
            case (ins[15:12])
                opBne: if (a != b) next = next + imm;
                opBeq: if (a == b) next = next + imm;
                opBgz: if ($signed(a) > 0) next = next + imm;
                opBlz: if ($signed(a) < 0) next = next + imm;
                opAdi: r[rt] = a + imm;
                opOri: r[rt] = a | imm;
                opLhi: r[rt] = {ins[7:0], 8'h00};
                opLwd: r[rt] = modelMem[addr[7:0]];
                opSwd: modelMem[addr[7:0]] = b;
                opJmp: next = {next[15:12], ins[11:0]};
                opJal: begin
                    r[linkReg] = next;
                    next = {next[15:12], ins[11:0]};
                end
                opRType: begin
                    case (ins[5:0])
                        fnAdd: r[rd] = a + b;
                        fnSub: r[rd] = a - b;
                        fnAnd: r[rd] = a & b;
                        fnOrr: r[rd] = a | b;
                        fnNot: r[rd] = ~a;
                        fnTcp: r[rd] = 16'd0 - a;
                        fnShl: r[rd] = {a[14:0], 1'b0};
                        fnShr: r[rd] = {a[15], a[15:1]};
                        fnWwd: expWwd.push_back(a);
                        fnJpr: next = a;
                        fnJrl: begin
                            r[linkReg] = next;
                            next = a;
                        end
                        fnHlt: done = 1'b1;
                        default: ;
                    endcase
                end
                default: ;
            endcase
            pc = next;
        end
    endtask

    task automatic checkValue(input string what, input logic [15:0] got,
            input logic [15:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic runProgram(input int p);
        logic [15:0] gotWwd [$];
        logic [15:0] portAtHalt;
        logic [15:0] countAtHalt;
        int cycles;
        runModel(p);
        @(negedge Clk);
        curProg = p;
        rstN = 1'b0;
        repeat (3) @(negedge Clk);
        rstN = 1'b1;
        checkValue($sformatf("%s retiredCount after reset", progName[p]), retiredCount, 16'h0);
        cycles = 0;
        while (retiredCount == 16'h0 && cycles < progCycles[p]) begin
            checkValue($sformatf("%s halted before retire", progName[p]), 16'(halted), 16'h0);
            checkValue($sformatf("%s wwdValid before retire", progName[p]),
                16'(wwdValid), 16'h0);
            @(negedge Clk);
            cycles++;
        end
        while (!halted && cycles < progCycles[p]) begin
            if (wwdValid) begin
                gotWwd.push_back(outputPort);
            end
            @(negedge Clk);
            cycles++;
        end
        if (wwdValid) begin
            gotWwd.push_back(outputPort);
        end
        assert (halted) else begin
            failures++;
            $display("program %s did not halt within %0d cycles", progName[p], progCycles[p]);
        end
        if (halted) begin
            checkValue($sformatf("%s retiredCount", progName[p]), retiredCount,
                16'(expRetired));
            checkValue($sformatf("%s wwd pulses", progName[p]), 16'(gotWwd.size()),
                16'(expWwd.size()));
            for (int i = 0; i < expWwd.size() && i < gotWwd.size(); i++) begin
                checkValue($sformatf("%s wwd %0d", progName[p], i), gotWwd[i], expWwd[i]);
            end
            for (int i = 0; i < 256; i++) begin
                checkValue($sformatf("%s dmem[%0d]", progName[p], i), dmem[i], modelMem[i]);
            end
            portAtHalt = outputPort;
            countAtHalt = retiredCount;
            // the core must stay frozen after halt
            repeat (10) begin
                @(negedge Clk);
                checkValue($sformatf("%s port after halt", progName[p]), outputPort, portAtHalt);
                checkValue($sformatf("%s count after halt", progName[p]), retiredCount,
                    countAtHalt);
                checkValue($sformatf("%s wwdValid after halt", progName[p]),
                    16'(wwdValid), 16'h0);
                checkValue($sformatf("%s halted", progName[p]), 16'(halted), 16'h1);
            end
        end
    endtask

    initial begin
        rstN = 1'b0;
        curProg = 0;
        mismatches = 0;
        failures = 0;
        lfsrState = 32'h4cf954bd;
        buildPrograms();
        for (int p = 0; p < $size(progName); p++) begin
            runProgram(p);
        end
        $display("mismatches: %0d, other failures: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
hdl/cpuPkg.sv
hdl/stageLink.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/writebackStage.sv
hdl/cpuCore.sv
tb/cpuCoreTb.sv
